// ==== hw/cpuTypesPkg.sv ====
package cpuTypesPkg;

    // Data and address word
    typedef logic [31:0] word_t;

    // Raw instruction as fetched
    typedef logic [31:0] instr_t;

    typedef logic [4:0] regAddr_t;  // Index into the 32-entry register file

    // ALU operation code, values live with the ISA constants
    typedef logic [3:0] aluOp_t;

    typedef logic [2:0] immSel_t;   // I, S, B, U or J immediate format

endpackage

// ==== hw/isaPkg.sv ====
package isaPkg;

    // Major opcodes of the supported RV32I subset
    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opSystem = 7'b1110011;  // ecall

    // ALU operations
    localparam cpuTypesPkg::aluOp_t aluAdd   = 4'd0;
    localparam cpuTypesPkg::aluOp_t aluSub   = 4'd1;
    localparam cpuTypesPkg::aluOp_t aluAnd   = 4'd2;
    localparam cpuTypesPkg::aluOp_t aluOr    = 4'd3;
    localparam cpuTypesPkg::aluOp_t aluXor   = 4'd4;
    localparam cpuTypesPkg::aluOp_t aluSlt   = 4'd5;   // Signed compare
    localparam cpuTypesPkg::aluOp_t aluSll   = 4'd6;
    localparam cpuTypesPkg::aluOp_t aluSrl   = 4'd7;
    localparam cpuTypesPkg::aluOp_t aluSra   = 4'd8;
    localparam cpuTypesPkg::aluOp_t aluPassB = 4'd9;   // lui result is the immediate

    // Branch conditions in funct3
    localparam logic [2:0] f3Beq = 3'b000;
    localparam logic [2:0] f3Bne = 3'b001;
    localparam logic [2:0] f3Blt = 3'b100;
    localparam logic [2:0] f3Bge = 3'b101;

    // Core run state
    typedef enum logic [1:0] {
        stIdle,
        stRun,
        stHalt
    } coreState_t;

endpackage

// ==== hw/fetchUnit.sv ====
module fetchUnit #(
    parameter int imemWords = 64
) (
    input  logic                           CLK,
    input  logic                           arstN,
    input  logic                           start,
    input  logic                           isHalt,
    input  logic                           branchTaken,
    input  logic                           imemWe,
    input  logic [$clog2(imemWords)-1:0]   imemAddr,
    input  cpuTypesPkg::instr_t            imemData,
    input  cpuTypesPkg::word_t             targetPc,
    output cpuTypesPkg::word_t             pc,
    output cpuTypesPkg::instr_t            instr,
    output logic                           running,
    output logic                           halted
);
    import cpuTypesPkg::*;
    import isaPkg::*;

    localparam int idxBits = $clog2(imemWords);

    coreState_t state;
    word_t      pcNext;
    instr_t     imem [imemWords];

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            state <= stIdle;
        end else begin
            case (state)
                stIdle:  if (start) state <= stRun;
                stRun:   if (isHalt) state <= stHalt;
                default: state <= state;  // Halt is terminal until reset
            endcase
        end
    end

    // Taken branch or jal redirects, otherwise fall through
    assign pcNext = branchTaken ? targetPc : pc + 32'd4;

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (state == stRun && !isHalt) begin
            pc <= pcNext;  // Holds on ecall so the halted pc stays put
        end
    end

    // Program load port
    always_ff @(posedge CLK) begin
        if (imemWe && state == stIdle) begin
            imem[imemAddr] <= imemData;
        end
    end

    assign instr   = imem[pc[idxBits+1:2]];  // Word index of pc
    assign running = (state == stRun);
    assign halted  = (state == stHalt);

    // Loading a running program would corrupt it
    loadOnlyIdle: assert property (@(posedge CLK) disable iff (!arstN)
        imemWe |-> state == stIdle)
        else $error("imemWe asserted while core is not idle");

endmodule

// ==== hw/instrDecoder.sv ====
module instrDecoder (
    input  cpuTypesPkg::instr_t    instr,
    output cpuTypesPkg::regAddr_t  rs1,
    output cpuTypesPkg::regAddr_t  rs2,
    output cpuTypesPkg::regAddr_t  rd,
    output cpuTypesPkg::word_t     imm,
    output cpuTypesPkg::aluOp_t    aluOp,
    output logic [2:0]             funct3,
    output logic                   aluSrcImm,
    output logic                   isBranch,
    output logic                   isJal,
    output logic                   memRead,
    output logic                   memWrite,
    output logic                   wbFromMem,
    output logic                   wbLink,
    output logic                   regWrite,
    output logic                   isHalt
);
    import cpuTypesPkg::*;
    import isaPkg::*;

    localparam immSel_t immI = 3'd0;
    localparam immSel_t immS = 3'd1;
    localparam immSel_t immB = 3'd2;
    localparam immSel_t immU = 3'd3;
    localparam immSel_t immJ = 3'd4;

    logic [6:0] opcode;
    immSel_t    immSel;
    logic       writesRd;

    // funct3 plus the alternate bit picks the ALU operation
    function automatic aluOp_t aluFromFunct(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? aluSub : aluAdd;
            3'b001:  return aluSll;
            3'b010:  return aluSlt;
            3'b100:  return aluXor;
            3'b101:  return alt ? aluSra : aluSrl;
            3'b110:  return aluOr;
            3'b111:  return aluAnd;
            default: return aluAdd;  // sltu not supported
        endcase
    endfunction

    assign opcode = instr[6:0];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];

    always_comb begin
        aluOp     = aluAdd;
        immSel    = immI;
        aluSrcImm = 1'b0;
        isBranch  = 1'b0;
        isJal     = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        wbFromMem = 1'b0;
        wbLink    = 1'b0;
        writesRd  = 1'b0;
        isHalt    = 1'b0;
        case (opcode)
            opOp: begin
                aluOp    = aluFromFunct(funct3, instr[30]);
                writesRd = 1'b1;
            end
            opOpImm: begin
                // Bit 30 is part of the immediate except for right shifts
                aluOp     = aluFromFunct(funct3, funct3 == 3'b101 && instr[30]);
                aluSrcImm = 1'b1;
                writesRd  = 1'b1;
            end
            opLoad: begin
                aluSrcImm = 1'b1;
                memRead   = 1'b1;
                wbFromMem = 1'b1;
                writesRd  = 1'b1;
            end
            opStore: begin
                immSel    = immS;
                aluSrcImm = 1'b1;
                memWrite  = 1'b1;
            end
            opBranch: begin
                immSel   = immB;
                isBranch = 1'b1;
            end
            opLui: begin
                immSel    = immU;
                aluOp     = aluPassB;
                aluSrcImm = 1'b1;
                writesRd  = 1'b1;
            end
            opJal: begin
                immSel   = immJ;
                isJal    = 1'b1;
                wbLink   = 1'b1;   // rd gets pc + 4
                writesRd = 1'b1;
            end
            opSystem: isHalt = 1'b1;
            default: ;             // Unknown opcodes retire as no-ops
        endcase
    end

    // x0 is never written
    assign regWrite = writesRd && (rd != '0);

    always_comb begin
        case (immSel)
            immS:    imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            immB:    imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
            immU:    imm = {instr[31:12], 12'b0};
            immJ:    imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                            instr[30:21], 1'b0};
            default: imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

endmodule

// ==== hw/regFile.sv ====
module regFile (
    input  logic                   CLK,
    input  logic                   arstN,
    input  logic                   we,
    input  cpuTypesPkg::regAddr_t  rs1,
    input  cpuTypesPkg::regAddr_t  rs2,
    input  cpuTypesPkg::regAddr_t  rd,
    input  cpuTypesPkg::word_t     wd,
    output cpuTypesPkg::word_t     rs1Data,
    output cpuTypesPkg::word_t     rs2Data
);
    import cpuTypesPkg::*;

    word_t regs [32];

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[rd] <= wd;
        end
    end

    // Asynchronous reads, no write-through needed in a single-cycle core
    assign rs1Data = regs[rs1];
    assign rs2Data = regs[rs2];

    // The decoder filters rd == 0, which keeps x0 at zero
    noWriteX0: assert property (@(posedge CLK) disable iff (!arstN)
        we |-> rd != '0)
        else $error("write to x0 reached the register file");

endmodule

// ==== hw/executeUnit.sv ====
module executeUnit (
    input  cpuTypesPkg::word_t   pc,
    input  cpuTypesPkg::word_t   rs1Data,
    input  cpuTypesPkg::word_t   rs2Data,
    input  cpuTypesPkg::word_t   imm,
    input  cpuTypesPkg::aluOp_t  aluOp,
    input  logic [2:0]           funct3,
    input  logic                 aluSrcImm,
    input  logic                 isBranch,
    input  logic                 isJal,
    output cpuTypesPkg::word_t   aluResult,
    output cpuTypesPkg::word_t   targetPc,
    output logic                 branchTaken
);
    import cpuTypesPkg::*;
    import isaPkg::*;

    word_t      opB;
    logic [4:0] shamt;
    logic       cond;

    assign opB   = aluSrcImm ? imm : rs2Data;
    assign shamt = opB[4:0];  // Only the low five bits shift

    always_comb begin
        case (aluOp)
            aluAdd:   aluResult = rs1Data + opB;
            aluSub:   aluResult = rs1Data - opB;
            aluAnd:   aluResult = rs1Data & opB;
            aluOr:    aluResult = rs1Data | opB;
            aluXor:   aluResult = rs1Data ^ opB;
            aluSlt:   aluResult = {31'b0, $signed(rs1Data) < $signed(opB)};
            aluSll:   aluResult = rs1Data << shamt;
            aluSrl:   aluResult = rs1Data >> shamt;
            aluSra:   aluResult = $signed(rs1Data) >>> shamt;  // Sign fills from the left
            aluPassB: aluResult = opB;
            default:  aluResult = rs1Data + opB;
        endcase
    end

    // Branch condition always compares the two registers
    always_comb begin
        case (funct3)
            f3Beq:   cond = (rs1Data == rs2Data);
            f3Bne:   cond = (rs1Data != rs2Data);
            f3Blt:   cond = ($signed(rs1Data) < $signed(rs2Data));
            f3Bge:   cond = ($signed(rs1Data) >= $signed(rs2Data));
            default: cond = 1'b0;
        endcase
    end

    assign branchTaken = isJal || (isBranch && cond);
    assign targetPc    = pc + imm;  // Same adder for B and J offsets

endmodule

// ==== hw/resultUnit.sv ====
module resultUnit #(
    parameter int dmemWords = 64
) (
    input  logic                CLK,
    input  logic                running,
    input  logic                memRead,
    input  logic                memWrite,
    input  logic                wbFromMem,
    input  logic                wbLink,
    input  cpuTypesPkg::word_t  aluResult,
    input  cpuTypesPkg::word_t  rs2Data,
    input  cpuTypesPkg::word_t  pc,
    output cpuTypesPkg::word_t  wbData
);
    import cpuTypesPkg::*;

    localparam int idxBits = $clog2(dmemWords);

    // Starts out zeroed so unwritten words read 0
    word_t              dmem [dmemWords] = '{default: '0};
    logic [idxBits-1:0] wordIdx;
    word_t              loadData;

    assign wordIdx = aluResult[idxBits+1:2];  // Byte address to word index

    always_ff @(posedge CLK) begin
        if (running && memWrite) begin
            dmem[wordIdx] <= rs2Data;
        end
    end

    assign loadData = memRead ? dmem[wordIdx] : '0;

    // Link beats memory beats ALU
    always_comb begin
        if (wbLink) begin
            wbData = pc + 32'd4;
        end else if (wbFromMem) begin
            wbData = loadData;
        end else begin
            wbData = aluResult;
        end
    end

    // Only whole-word accesses exist, so the computed address must be aligned
    wordAligned: assert property (@(posedge CLK)
        running && (memRead || memWrite) |-> aluResult[1:0] == 2'b00)
        else $error("misaligned data memory access at %h", aluResult);

endmodule

// ==== hw/singleCycleCore.sv ====
module singleCycleCore #(
    parameter int imemWords = 64,
    parameter int dmemWords = 64
) (
    input  logic                           CLK,
    input  logic                           arstN,
    input  logic                           start,
    input  logic                           imemWe,
    input  logic [$clog2(imemWords)-1:0]   imemAddr,
    input  cpuTypesPkg::instr_t            imemData,
    output cpuTypesPkg::word_t             pc,
    output logic                           retire,
    output logic                           wbEn,
    output cpuTypesPkg::regAddr_t          wbReg,
    output cpuTypesPkg::word_t             wbData,
    output logic                           halted
);
    import cpuTypesPkg::*;

    instr_t     instr;
    regAddr_t   rs1;
    regAddr_t   rs2;
    word_t      imm;
    word_t      rs1Data;
    word_t      rs2Data;
    word_t      aluResult;
    word_t      targetPc;
    aluOp_t     aluOp;
    logic [2:0] funct3;
    logic       running;
    logic       aluSrcImm;
    logic       isBranch;
    logic       isJal;
    logic       memRead;
    logic       memWrite;
    logic       wbFromMem;
    logic       wbLink;
    logic       regWrite;
    logic       isHalt;
    logic       branchTaken;

    // One instruction per cycle while running
    assign retire = running;
    assign wbEn   = regWrite && running;

    fetchUnit #(
        .imemWords(imemWords)
    ) fetch_i (
        .CLK(CLK),
        .arstN(arstN),
        .start(start),
        .isHalt(isHalt),
        .branchTaken(branchTaken),
        .imemWe(imemWe),
        .imemAddr(imemAddr),
        .imemData(imemData),
        .targetPc(targetPc),
        .pc(pc),
        .instr(instr),
        .running(running),
        .halted(halted)
    );

    instrDecoder decode_i (
        .instr(instr),
        .rs1(rs1),
        .rs2(rs2),
        .rd(wbReg),
        .imm(imm),
        .aluOp(aluOp),
        .funct3(funct3),
        .aluSrcImm(aluSrcImm),
        .isBranch(isBranch),
        .isJal(isJal),
        .memRead(memRead),
        .memWrite(memWrite),
        .wbFromMem(wbFromMem),
        .wbLink(wbLink),
        .regWrite(regWrite),
        .isHalt(isHalt)
    );

    regFile regs_i (
        .CLK(CLK),
        .arstN(arstN),
        .we(wbEn),
        .rs1(rs1),
        .rs2(rs2),
        .rd(wbReg),
        .wd(wbData),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data)
    );

    executeUnit execute_i (
        .pc(pc),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data),
        .imm(imm),
        .aluOp(aluOp),
        .funct3(funct3),
        .aluSrcImm(aluSrcImm),
        .isBranch(isBranch),
        .isJal(isJal),
        .aluResult(aluResult),
        .targetPc(targetPc),
        .branchTaken(branchTaken)
    );

    resultUnit #(
        .dmemWords(dmemWords)
    ) result_i (
        .CLK(CLK),
        .running(running),
        .memRead(memRead),
        .memWrite(memWrite),
        .wbFromMem(wbFromMem),
        .wbLink(wbLink),
        .aluResult(aluResult),
        .rs2Data(rs2Data),
        .pc(pc),
        .wbData(wbData)
    );

endmodule

// ==== verification/coreTb.sv ====
module coreTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int imemWords  = 64;
    localparam int dmemWords  = 64;
    localparam int numRows    = 25;
    localparam int cycleLimit = numRows + numRows + 20;  // Load, run, then slack

    typedef struct packed {
        logic [31:0] word;
        logic        runs;  // Low for instructions a branch or jump skips
        logic [31:0] pc;
        logic        wbEn;
        logic [4:0]  rd;
        logic [31:0] data;
    } row_t;

    logic        CLK;
    logic        arstN;
    logic        start;
    logic        imemWe;
    logic [5:0]  imemAddr;
    logic [31:0] imemData;
    logic [31:0] pc;
    logic        retire;
    logic        wbEn;
    logic [4:0]  wbReg;
    logic [31:0] wbData;
    logic        halted;
    int          cycles;

    // Program in address order with the retire values expected from RV32I rules
    row_t prog [numRows] = '{
        '{32'h00500093, 1'b1, 32'd0,  1'b1, 5'd1,  32'h0000_0005},  // addi x1, x0, 5
        '{32'hFFD00113, 1'b1, 32'd4,  1'b1, 5'd2,  32'hFFFF_FFFD},  // addi x2, x0, -3
        '{32'h002081B3, 1'b1, 32'd8,  1'b1, 5'd3,  32'h0000_0002},  // add x3, x1, x2
        '{32'h40208233, 1'b1, 32'd12, 1'b1, 5'd4,  32'h0000_0008},  // sub x4, x1, x2
        '{32'h0020F2B3, 1'b1, 32'd16, 1'b1, 5'd5,  32'h0000_0005},  // and x5, x1, x2
        '{32'h0020E333, 1'b1, 32'd20, 1'b1, 5'd6,  32'hFFFF_FFFD},  // or x6, x1, x2
        '{32'h0020C3B3, 1'b1, 32'd24, 1'b1, 5'd7,  32'hFFFF_FFF8},  // xor x7, x1, x2
        '{32'h00112433, 1'b1, 32'd28, 1'b1, 5'd8,  32'h0000_0001},  // slt x8, x2, x1
        '{32'h00409493, 1'b1, 32'd32, 1'b1, 5'd9,  32'h0000_0050},  // slli x9, x1, 4
        '{32'h40115513, 1'b1, 32'd36, 1'b1, 5'd10, 32'hFFFF_FFFE},  // srai x10, x2, 1
        '{32'h01C15593, 1'b1, 32'd40, 1'b1, 5'd11, 32'h0000_000F},  // srli x11, x2, 28
        '{32'h00708013, 1'b1, 32'd44, 1'b0, 5'd0,  32'h0000_0000},  // addi x0, x1, 7
        '{32'h00702423, 1'b1, 32'd48, 1'b0, 5'd0,  32'h0000_0000},  // sw x7, 8(x0)
        '{32'h00802603, 1'b1, 32'd52, 1'b1, 5'd12, 32'hFFFF_FFF8},  // lw x12, 8(x0)
        '{32'h00C02683, 1'b1, 32'd56, 1'b1, 5'd13, 32'h0000_0000},  // lw x13, 12(x0)
        '{32'h00108463, 1'b1, 32'd60, 1'b0, 5'd0,  32'h0000_0000},  // beq x1, x1, +8
        '{32'h00100713, 1'b0, 32'd64, 1'b1, 5'd14, 32'h0000_0001},  // addi x14, x0, 1
        '{32'h00109463, 1'b1, 32'd68, 1'b0, 5'd0,  32'h0000_0000},  // bne x1, x1, +8
        '{32'h00114463, 1'b1, 32'd72, 1'b0, 5'd0,  32'h0000_0000},  // blt x2, x1, +8
        '{32'h00200713, 1'b0, 32'd76, 1'b1, 5'd14, 32'h0000_0002},  // addi x14, x0, 2
        '{32'h00115463, 1'b1, 32'd80, 1'b0, 5'd0,  32'h0000_0000},  // bge x2, x1, +8
        '{32'h123457B7, 1'b1, 32'd84, 1'b1, 5'd15, 32'h1234_5000},  // lui x15, 0x12345
        '{32'h0080086F, 1'b1, 32'd88, 1'b1, 5'd16, 32'h0000_005C},  // jal x16, +8
        '{32'h00300713, 1'b0, 32'd92, 1'b1, 5'd14, 32'h0000_0003},  // addi x14, x0, 3
        '{32'h00000073, 1'b1, 32'd96, 1'b0, 5'd0,  32'h0000_0000}   // ecall
    };

    singleCycleCore #(
        .imemWords(imemWords),
        .dmemWords(dmemWords)
    ) dut_i (
        .CLK(CLK),
        .arstN(arstN),
        .start(start),
        .imemWe(imemWe),
        .imemAddr(imemAddr),
        .imemData(imemData),
        .pc(pc),
        .retire(retire),
        .wbEn(wbEn),
        .wbReg(wbReg),
        .wbData(wbData),
        .halted(halted)
    );

    always #50 CLK = ~CLK;

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles > cycleLimit) begin
            $display("simulation ran past %0d cycles without finishing", cycleLimit);
            $display("test failed");
            $fatal(1, "timeout");
        end
    end

    task automatic compareValue(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
            $display("test failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // Core must sit idle while the program goes in
    task automatic loadProgram();
        for (int i = 0; i < numRows; i++) begin
            compareValue($sformatf("idle retire %0d", i), 32'd0, 32'(retire));
            compareValue($sformatf("idle wbEn %0d", i), 32'd0, 32'(wbEn));
            compareValue($sformatf("idle halted %0d", i), 32'd0, 32'(halted));
            compareValue($sformatf("idle pc %0d", i), 32'd0, pc);
            imemWe   = 1'b1;
            imemAddr = 6'(i);
            imemData = prog[i].word;
            @(negedge CLK);
        end
        imemWe = 1'b0;
    endtask

    task automatic runProgram();
        for (int i = 0; i < numRows; i++) begin
            if (prog[i].runs) begin
                compareValue($sformatf("retire row %0d", i), 32'd1, 32'(retire));
                compareValue($sformatf("pc row %0d", i), prog[i].pc, pc);
                compareValue($sformatf("wbEn row %0d", i), 32'(prog[i].wbEn), 32'(wbEn));
                if (prog[i].wbEn) begin
                    compareValue($sformatf("wbReg row %0d", i), 32'(prog[i].rd), 32'(wbReg));
                    compareValue($sformatf("wbData row %0d", i), prog[i].data, wbData);
                end
                @(negedge CLK);
            end
        end
    endtask

    initial begin
        CLK      = 1'b0;
        arstN    = 1'b0;
        start    = 1'b0;
        imemWe   = 1'b0;
        imemAddr = '0;
        imemData = '0;
        cycles   = 0;
        repeat (3) @(negedge CLK);
        arstN = 1'b1;
        loadProgram();
        start = 1'b1;  // First instruction executes in the following cycle
        @(negedge CLK);
        start = 1'b0;
        runProgram();
        repeat (5) begin
            compareValue("halted after ecall", 32'd1, 32'(halted));
            compareValue("retire after ecall", 32'd0, 32'(retire));
            compareValue("wbEn after ecall", 32'd0, 32'(wbEn));
            compareValue("pc after ecall", prog[numRows-1].pc, pc);
            @(negedge CLK);
        end
        $display("test passed");
        $finish;
    end

endmodule

// ==== sources.f ====
hw/cpuTypesPkg.sv
hw/isaPkg.sv
hw/fetchUnit.sv
hw/instrDecoder.sv
hw/regFile.sv
hw/executeUnit.sv
hw/resultUnit.sv
hw/singleCycleCore.sv
verification/coreTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build the core testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert --top-module coreTb -f sources.f -o coreSim &&
    ./obj_dir/coreSim | tee /dev/stderr | grep -q "test passed" &&
    echo "simulation PASS" ||
    { echo "simulation FAIL"; exit 1; }
